// ==== source/trail_pkg.sv ====
// trail subsystem shared definitions
// grid, tile and colour constants plus the state and code enums
`default_nettype none

package trail_pkg;

	// playfield grid
	localparam int unsigned GRID_W     = 32;
	localparam int unsigned CELL_BITS  = 5;
	localparam int unsigned GRID_CELLS = GRID_W * GRID_W;

	// frame buffer geometry, one 16-bit word is one tile row
	localparam int unsigned TILE_ROWS         = 4;
	localparam int unsigned FB_WORDS_PER_LINE = 32;
	localparam int unsigned FB_ADDR_BITS      = 12;

	// pixel values per player
	localparam logic [3:0] BLUE_COLOR = 4'h3;
	localparam logic [3:0] RED_COLOR  = 4'hC;

	typedef enum logic [1:0] {
		GS_TITLE,
		GS_READY,
		GS_PLAY,
		GS_OVER
	} game_state_e;

	typedef enum logic [1:0] {
		DIR_UP,
		DIR_DOWN,
		DIR_LEFT,
		DIR_RIGHT
	} dir_e;

	typedef enum logic [1:0] {
		TK_NONE,
		TK_HORIZ,
		TK_VERT,
		TK_CORNER
	} trail_kind_e;

	typedef enum logic {
		P_BLUE,
		P_RED
	} player_e;

	typedef enum logic [2:0] {
		WS_IDLE,
		WS_CHECK,
		WS_ROM_WAIT,
		WS_WR_REQ,
		WS_WR_REL,
		WS_NEXT_ROW,
		WS_ACK,
		WS_RELEASE
	} writer_state_e;

endpackage

`default_nettype wire

// ==== source/trail_step_if.sv ====
// one trail step from a classifier to the writer
// four-phase req/ack, payload changes only while both are low
`default_nettype none

interface trail_step_if
	import trail_pkg::*;
();

	logic                 req;
	logic                 ack;
	logic [CELL_BITS-1:0] cell_x;
	logic [CELL_BITS-1:0] cell_y;
	trail_kind_e          kind;

	// classifier side
	modport source (
		output req, cell_x, cell_y, kind,
		input  ack
	);

	// writer side
	modport sink (
		input  req, cell_x, cell_y, kind,
		output ack
	);

endinterface

`default_nettype wire

// ==== source/trail_classifier.sv ====
// per-player trail classifier
// watches for cell changes and issues one step for the cell left behind
`default_nettype none

module trail_classifier
	import trail_pkg::*;
(
	input  logic                 Clk,
	input  logic                 rst_n,
	input  game_state_e          game_state,
	input  logic [CELL_BITS-1:0] pos_x,
	input  logic [CELL_BITS-1:0] pos_y,
	input  dir_e                 dir,
	trail_step_if.source         step
);

	logic [CELL_BITS-1:0] last_x;
	logic [CELL_BITS-1:0] last_y;
	dir_e                 last_dir;
	logic [CELL_BITS-1:0] new_x;
	logic [CELL_BITS-1:0] new_y;
	dir_e                 new_dir;
	logic                 idle;
	logic                 moved;
	trail_kind_e          piece;

	assign idle  = !step.req && !step.ack;
	assign moved = (pos_x != last_x) || (pos_y != last_y);

	// turn since the last step leaves a corner behind
	always_comb
	begin
		if (dir != last_dir)
			piece = TK_CORNER;
		else if (dir == DIR_LEFT || dir == DIR_RIGHT)
			piece = TK_HORIZ;
		else
			piece = TK_VERT;
	end

	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			step.req <= 1'b0;
			last_x   <= '0;
			last_y   <= '0;
			last_dir <= DIR_UP;
		end
		else if (game_state != GS_PLAY)
		begin
			// follow the cycle until play starts
			step.req <= 1'b0;
			last_x   <= pos_x;
			last_y   <= pos_y;
			last_dir <= dir;
		end
		else if (step.req && step.ack)
		begin
			step.req <= 1'b0;
			last_x   <= new_x;
			last_y   <= new_y;
			last_dir <= new_dir;
		end
		else if (idle && moved)
			step.req <= 1'b1;
	end

	// payload and entered cell, latched as req goes up
	always_ff @(posedge Clk)
	begin
		if (idle && moved)
		begin
			step.cell_x <= last_x;
			step.cell_y <= last_y;
			step.kind   <= piece;
			new_x       <= pos_x;
			new_y       <= pos_y;
			new_dir     <= dir;
		end
	end

	a_kind_valid: assert property (@(posedge Clk) disable iff (!rst_n)
		step.req |-> step.kind != TK_NONE);

endmodule

`default_nettype wire

// ==== source/trail_tile_rom.sv ====
// tile row patterns for each trail kind, bit 3 is the leftmost pixel
// registered read, one cycle from address to data
`default_nettype none

module trail_tile_rom
	import trail_pkg::*;
(
	input  logic        Clk,
	input  trail_kind_e kind,
	input  logic [1:0]  row,
	output logic [3:0]  pattern
);

	always_ff @(posedge Clk)
	begin
		case (kind)
			TK_HORIZ:
			begin
				// two-pixel band through the middle rows
				case (row)
					2'd0: pattern <= 4'b0000;
					2'd1: pattern <= 4'b1111;
					2'd2: pattern <= 4'b1111;
					default: pattern <= 4'b0000;
				endcase
			end
			TK_VERT:
				pattern <= 4'b0110;
			TK_CORNER:
			begin
				// union of the horizontal and vertical shapes
				case (row)
					2'd0: pattern <= 4'b0110;
					2'd1: pattern <= 4'b1111;
					2'd2: pattern <= 4'b1111;
					default: pattern <= 4'b0110;
				endcase
			end
			default:
				pattern <= 4'b0000;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/trail_map.sv ====
// trail occupancy map, one valid and owner bit pair per grid cell
// check-and-mark in one cycle, full clear sweep on entering ready
`default_nettype none

module trail_map
	import trail_pkg::*;
(
	input  logic                 Clk,
	input  logic                 rst_n,
	input  game_state_e          game_state,
	input  logic                 check,
	input  logic [CELL_BITS-1:0] cell_x,
	input  logic [CELL_BITS-1:0] cell_y,
	input  player_e              owner,
	output logic                 occupied,
	output logic                 clearing
);

	// bit 1 valid, bit 0 owner
	logic [1:0]             cells [GRID_CELLS];
	logic [2*CELL_BITS-1:0] cell_idx;
	logic [2*CELL_BITS-1:0] sweep_addr;
	logic [2*CELL_BITS-1:0] wr_addr;
	logic [1:0]             wr_data;
	logic                   wr_en;
	game_state_e            prev_state;
	logic                   start_clear;

	assign cell_idx    = (2*CELL_BITS)'(cell_y * GRID_W + cell_x);
	assign start_clear = (game_state == GS_READY) && (prev_state != GS_READY);

	// sweep runs for exactly one pass over the grid
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prev_state <= GS_TITLE;
			clearing   <= 1'b0;
			sweep_addr <= '0;
		end
		else
		begin
			prev_state <= game_state;
			if (start_clear)
			begin
				clearing   <= 1'b1;
				sweep_addr <= '0;
			end
			else if (clearing)
			begin
				sweep_addr <= sweep_addr + 1'b1;
				if (sweep_addr == (2*CELL_BITS)'(GRID_CELLS - 1))
					clearing <= 1'b0;
			end
		end
	end

	// single write port shared by the sweep and the marking
	assign wr_en   = clearing || check;
	assign wr_addr = clearing ? sweep_addr : cell_idx;
	assign wr_data = clearing ? 2'b00 : {1'b1, owner};

	always_ff @(posedge Clk)
	begin
		// old contents are read before the mark lands
		if (check)
			occupied <= cells[cell_idx][1];
		if (wr_en)
			cells[wr_addr] <= wr_data;
	end

	// the writer must hold off while the sweep owns the port
	a_no_check_in_clear: assert property (@(posedge Clk) disable iff (!rst_n)
		check |-> !clearing);

endmodule

`default_nettype wire

// ==== source/trail_writer.sv ====
// trail writer, arbitrates between the two players, marks the map and
// draws each tile as four frame buffer rows over a four-phase port
`default_nettype none

module trail_writer
	import trail_pkg::*;
(
	input  logic                    Clk,
	input  logic                    rst_n,
	input  game_state_e             game_state,
	trail_step_if.sink              blue_step,
	trail_step_if.sink              red_step,
	output logic                    map_check,
	output logic [CELL_BITS-1:0]    map_x,
	output logic [CELL_BITS-1:0]    map_y,
	output player_e                 map_owner,
	input  logic                    map_occupied,
	input  logic                    map_clearing,
	output trail_kind_e             rom_kind,
	output logic [1:0]              rom_row,
	input  logic [3:0]              rom_pattern,
	output logic                    fb_req,
	input  logic                    fb_ack,
	output logic [FB_ADDR_BITS-1:0] fb_addr,
	output logic [15:0]             fb_data,
	output logic                    collision_blue,
	output logic                    collision_red
);

	writer_state_e          state;
	player_e                sel;
	player_e                last_served;
	player_e                pick;
	logic [1:0]             row;
	logic                   ack_r;
	logic                   sel_req;
	logic [CELL_BITS-1:0]   cur_x;
	logic [CELL_BITS-1:0]   cur_y;
	trail_kind_e            cur_kind;
	logic [3:0]             color;
	logic [15:0]            row_data;
	logic [FB_ADDR_BITS-1:0] row_addr;

	// alternate when both are waiting
	always_comb
	begin
		if (blue_step.req && red_step.req)
			pick = (last_served == P_BLUE) ? P_RED : P_BLUE;
		else if (blue_step.req)
			pick = P_BLUE;
		else
			pick = P_RED;
	end

	assign sel_req       = (sel == P_BLUE) ? blue_step.req : red_step.req;
	assign blue_step.ack = ack_r && (sel == P_BLUE);
	assign red_step.ack  = ack_r && (sel == P_RED);

	assign map_check = (state == WS_CHECK);
	assign map_x     = cur_x;
	assign map_y     = cur_y;
	assign map_owner = sel;
	assign rom_kind  = cur_kind;
	assign rom_row   = row;

	// pattern bit to colour nibble
	always_comb
	begin
		color = (sel == P_BLUE) ? BLUE_COLOR : RED_COLOR;
		for (int i = 0; i < 4; i++)
			row_data[4*i +: 4] = rom_pattern[i] ? color : 4'h0;
	end

	assign row_addr = FB_ADDR_BITS'((cur_y * TILE_ROWS + row) * FB_WORDS_PER_LINE + cur_x);

	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state          <= WS_IDLE;
			sel            <= P_BLUE;
			last_served    <= P_RED;
			row            <= '0;
			ack_r          <= 1'b0;
			fb_req         <= 1'b0;
			collision_blue <= 1'b0;
			collision_red  <= 1'b0;
		end
		else
		begin
			// map answer for the check is only present on the first row
			if (game_state == GS_READY)
			begin
				collision_blue <= 1'b0;
				collision_red  <= 1'b0;
			end
			else if (state == WS_ROM_WAIT && row == 2'd0 && map_occupied)
			begin
				if (sel == P_BLUE)
					collision_blue <= 1'b1;
				else
					collision_red <= 1'b1;
			end

			unique case (state)
				WS_IDLE:
				begin
					if (game_state == GS_PLAY && !map_clearing &&
						(blue_step.req || red_step.req))
					begin
						sel   <= pick;
						row   <= '0;
						state <= WS_CHECK;
					end
				end
				WS_CHECK:
					state <= WS_ROM_WAIT;
				WS_ROM_WAIT:
				begin
					fb_req <= 1'b1;
					state  <= WS_WR_REQ;
				end
				WS_WR_REQ:
				begin
					if (fb_ack)
					begin
						fb_req <= 1'b0;
						state  <= WS_WR_REL;
					end
				end
				WS_WR_REL:
				begin
					if (!fb_ack)
					begin
						if (row == 2'(TILE_ROWS - 1))
						begin
							ack_r <= 1'b1;
							state <= WS_ACK;
						end
						else
						begin
							row   <= row + 1'b1;
							state <= WS_NEXT_ROW;
						end
					end
				end
				// gives the ROM its cycle for the new row
				WS_NEXT_ROW:
					state <= WS_ROM_WAIT;
				WS_ACK:
				begin
					if (!sel_req)
					begin
						ack_r       <= 1'b0;
						last_served <= sel;
						state       <= WS_RELEASE;
					end
				end
				WS_RELEASE:
					state <= WS_IDLE;
				default:
					state <= WS_IDLE;
			endcase
		end
	end

	always_ff @(posedge Clk)
	begin
		if (state == WS_IDLE)
		begin
			cur_x    <= (pick == P_BLUE) ? blue_step.cell_x : red_step.cell_x;
			cur_y    <= (pick == P_BLUE) ? blue_step.cell_y : red_step.cell_y;
			cur_kind <= (pick == P_BLUE) ? blue_step.kind : red_step.kind;
		end
		if (state == WS_ROM_WAIT)
		begin
			fb_addr <= row_addr;
			fb_data <= row_data;
		end
	end

	a_fb_hold: assert property (@(posedge Clk) disable iff (!rst_n)
		fb_req && !fb_ack |=> $stable(fb_addr) && $stable(fb_data));

endmodule

`default_nettype wire

// ==== source/trail_engine.sv ====
// light-cycle trail engine top level
// two classifiers feed one writer that draws into an external frame buffer
`default_nettype none

module trail_engine
	import trail_pkg::*;
(
	input  logic                    Clk,
	input  logic                    rst_n,
	input  game_state_e             game_state,
	input  logic [CELL_BITS-1:0]    blue_x,
	input  logic [CELL_BITS-1:0]    blue_y,
	input  logic [CELL_BITS-1:0]    red_x,
	input  logic [CELL_BITS-1:0]    red_y,
	input  dir_e                    blue_dir,
	input  dir_e                    red_dir,
	output logic                    fb_req,
	output logic [FB_ADDR_BITS-1:0] fb_addr,
	output logic [15:0]             fb_data,
	input  logic                    fb_ack,
	output logic                    collision_blue,
	output logic                    collision_red
);

	logic                 map_check;
	logic [CELL_BITS-1:0] map_x;
	logic [CELL_BITS-1:0] map_y;
	player_e              map_owner;
	logic                 map_occupied;
	logic                 map_clearing;
	trail_kind_e          rom_kind;
	logic [1:0]           rom_row;
	logic [3:0]           rom_pattern;

	trail_step_if blue_step_bus ();
	trail_step_if red_step_bus ();

	trail_classifier i_blue_cls (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.game_state (game_state),
		.pos_x      (blue_x),
		.pos_y      (blue_y),
		.dir        (blue_dir),
		.step       (blue_step_bus.source)
	);

	trail_classifier i_red_cls (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.game_state (game_state),
		.pos_x      (red_x),
		.pos_y      (red_y),
		.dir        (red_dir),
		.step       (red_step_bus.source)
	);

	trail_writer i_writer (
		.Clk            (Clk),
		.rst_n          (rst_n),
		.game_state     (game_state),
		.blue_step      (blue_step_bus.sink),
		.red_step       (red_step_bus.sink),
		.map_check      (map_check),
		.map_x          (map_x),
		.map_y          (map_y),
		.map_owner      (map_owner),
		.map_occupied   (map_occupied),
		.map_clearing   (map_clearing),
		.rom_kind       (rom_kind),
		.rom_row        (rom_row),
		.rom_pattern    (rom_pattern),
		.fb_req         (fb_req),
		.fb_ack         (fb_ack),
		.fb_addr        (fb_addr),
		.fb_data        (fb_data),
		.collision_blue (collision_blue),
		.collision_red  (collision_red)
	);

	trail_tile_rom i_rom (
		.Clk     (Clk),
		.kind    (rom_kind),
		.row     (rom_row),
		.pattern (rom_pattern)
	);

	trail_map i_map (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.game_state (game_state),
		.check      (map_check),
		.cell_x     (map_x),
		.cell_y     (map_y),
		.owner      (map_owner),
		.occupied   (map_occupied),
		.clearing   (map_clearing)
	);

endmodule

`default_nettype wire

// ==== test/tb_trail_engine.sv ====
// trail engine testbench
// table of moves against a frame buffer responder and a reference model
`default_nettype none

module tb_trail_engine
	import trail_pkg::*;
();

	typedef struct {
		game_state_e          gs;
		logic [CELL_BITS-1:0] blue_x;
		logic [CELL_BITS-1:0] blue_y;
		dir_e                 blue_dir;
		logic [CELL_BITS-1:0] red_x;
		logic [CELL_BITS-1:0] red_y;
		dir_e                 red_dir;
		logic                 exp_col_blue;
		logic                 exp_col_red;
		string                name;
	} move_t;

	typedef struct packed {
		player_e              player;
		logic [CELL_BITS-1:0] x;
		logic [CELL_BITS-1:0] y;
		trail_kind_e          kind;
	} step_t;

	logic                    Clk;
	logic                    rst_n;
	game_state_e             game_state;
	logic [CELL_BITS-1:0]    blue_x;
	logic [CELL_BITS-1:0]    blue_y;
	logic [CELL_BITS-1:0]    red_x;
	logic [CELL_BITS-1:0]    red_y;
	dir_e                    blue_dir;
	dir_e                    red_dir;
	logic                    fb_req;
	logic [FB_ADDR_BITS-1:0] fb_addr;
	logic [15:0]             fb_data;
	logic                    fb_ack;
	logic                    collision_blue;
	logic                    collision_red;

	move_t                   moves [$];
	step_t                   exp_steps [$];
	logic [15:0]             fb_mem [int];
	int                      write_count;
	int unsigned             ack_delay;
	logic                    table_ready;
	// reference copy of each player's last accepted cell and direction
	logic [CELL_BITS-1:0]    last_x [2];
	logic [CELL_BITS-1:0]    last_y [2];
	dir_e                    last_dir [2];

	trail_engine i_dut (
		.Clk            (Clk),
		.rst_n          (rst_n),
		.game_state     (game_state),
		.blue_x         (blue_x),
		.blue_y         (blue_y),
		.red_x          (red_x),
		.red_y          (red_y),
		.blue_dir       (blue_dir),
		.red_dir        (red_dir),
		.fb_req         (fb_req),
		.fb_addr        (fb_addr),
		.fb_data        (fb_data),
		.fb_ack         (fb_ack),
		.collision_blue (collision_blue),
		.collision_red  (collision_red)
	);

	always
		#50 Clk = ~Clk;

	// frame buffer memory with a four-phase port and a random ack delay
	always
	begin
		@(posedge Clk);
		if (rst_n && fb_req && !fb_ack)
		begin
			ack_delay = $urandom_range(3, 0);
			repeat (ack_delay) @(posedge Clk);
			fb_mem[int'(fb_addr)] = fb_data;
			write_count++;
			fb_ack <= 1'b1;
			while (fb_req)
				@(posedge Clk);
			fb_ack <= 1'b0;
		end
	end

	function automatic void add_move(input game_state_e gs, input int bx, input int by,
		input dir_e bd, input int rx, input int ry, input dir_e rd,
		input logic cb, input logic cr, input string name);
		move_t m;
		m.gs           = gs;
		m.blue_x       = CELL_BITS'(bx);
		m.blue_y       = CELL_BITS'(by);
		m.blue_dir     = bd;
		m.red_x        = CELL_BITS'(rx);
		m.red_y        = CELL_BITS'(ry);
		m.red_dir      = rd;
		m.exp_col_blue = cb;
		m.exp_col_red  = cr;
		m.name         = name;
		moves.push_back(m);
	endfunction

	function automatic void build_table();
		add_move(GS_TITLE, 2, 2, DIR_RIGHT, 12, 3, DIR_LEFT, 0, 0, "title_idle");
		add_move(GS_TITLE, 3, 2, DIR_RIGHT, 11, 3, DIR_LEFT, 0, 0, "title_moving");
		add_move(GS_READY, 4, 2, DIR_RIGHT, 10, 3, DIR_LEFT, 0, 0, "ready_clear");
		add_move(GS_PLAY, 4, 2, DIR_RIGHT, 10, 3, DIR_LEFT, 0, 0, "play_start");
		add_move(GS_PLAY, 5, 2, DIR_RIGHT, 10, 3, DIR_LEFT, 0, 0, "blue_horiz_1");
		add_move(GS_PLAY, 6, 2, DIR_RIGHT, 10, 3, DIR_LEFT, 0, 0, "blue_horiz_2");
		add_move(GS_PLAY, 6, 3, DIR_DOWN, 10, 3, DIR_LEFT, 0, 0, "blue_turn_down");
		add_move(GS_PLAY, 6, 4, DIR_DOWN, 10, 3, DIR_LEFT, 0, 0, "blue_vert_1");
		add_move(GS_PLAY, 6, 5, DIR_DOWN, 10, 3, DIR_LEFT, 0, 0, "blue_vert_2");
		add_move(GS_PLAY, 7, 5, DIR_RIGHT, 9, 3, DIR_LEFT, 0, 0, "both_step");
		add_move(GS_PLAY, 8, 5, DIR_RIGHT, 8, 3, DIR_LEFT, 0, 0, "both_step_2");
		add_move(GS_PLAY, 8, 5, DIR_RIGHT, 8, 2, DIR_UP, 0, 0, "red_turn_up");
		add_move(GS_PLAY, 8, 5, DIR_RIGHT, 7, 2, DIR_LEFT, 0, 0, "red_turn_left");
		add_move(GS_PLAY, 8, 5, DIR_RIGHT, 6, 2, DIR_LEFT, 0, 0, "red_enters_trail");
		add_move(GS_PLAY, 8, 5, DIR_RIGHT, 5, 2, DIR_LEFT, 0, 1, "red_hits_blue");
		add_move(GS_PLAY, 9, 5, DIR_RIGHT, 5, 2, DIR_LEFT, 0, 1, "flag_sticky");
		add_move(GS_OVER, 9, 5, DIR_RIGHT, 5, 2, DIR_LEFT, 0, 1, "over_holds");
		add_move(GS_READY, 4, 2, DIR_RIGHT, 6, 2, DIR_LEFT, 0, 0, "ready_again");
		add_move(GS_PLAY, 5, 2, DIR_RIGHT, 6, 1, DIR_UP, 0, 0, "fresh_run");
		add_move(GS_PLAY, 6, 2, DIR_RIGHT, 6, 0, DIR_UP, 0, 0, "fresh_run_2");
		add_move(GS_PLAY, 7, 2, DIR_RIGHT, 6, 0, DIR_UP, 1, 0, "blue_hits_red");
	endfunction

	// tile row as the display expects it with the leftmost pixel in the top nibble
	function automatic logic [15:0] expected_word(input player_e p, input trail_kind_e k,
		input int row);
		logic [3:0]  pat;
		logic [3:0]  color;
		logic [15:0] word;
		case (k)
			TK_HORIZ:  pat = (row == 1 || row == 2) ? 4'b1111 : 4'b0000;
			TK_VERT:   pat = 4'b0110;
			TK_CORNER: pat = (row == 1 || row == 2) ? 4'b1111 : 4'b0110;
			default:   pat = 4'b0000;
		endcase
		color = (p == P_BLUE) ? BLUE_COLOR : RED_COLOR;
		word  = '0;
		for (int px = 0; px < 4; px++)
			if (pat[3-px])
				word[15-4*px -: 4] = color;
		return word;
	endfunction

	function automatic int fb_address(input int x, input int y, input int row);
		return (y * TILE_ROWS + row) * FB_WORDS_PER_LINE + x;
	endfunction

	// one step per cell left behind while in play
	function automatic void predict_player(input player_e p, input game_state_e gs,
		input logic [CELL_BITS-1:0] x, input logic [CELL_BITS-1:0] y, input dir_e d);
		step_t s;
		if (gs == GS_PLAY && (x != last_x[p] || y != last_y[p]))
		begin
			s.player = p;
			s.x      = last_x[p];
			s.y      = last_y[p];
			if (d != last_dir[p])
				s.kind = TK_CORNER;
			else if (d == DIR_LEFT || d == DIR_RIGHT)
				s.kind = TK_HORIZ;
			else
				s.kind = TK_VERT;
			exp_steps.push_back(s);
		end
		if (gs != GS_PLAY || x != last_x[p] || y != last_y[p])
		begin
			last_x[p]   = x;
			last_y[p]   = y;
			last_dir[p] = d;
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < 20)
		begin
			@(posedge Clk);
			if (fb_req || fb_ack)
				quiet = 0;
			else
				quiet++;
		end
	endtask

	task automatic apply_move(input move_t m);
		int          addr;
		logic [15:0] actual;
		@(posedge Clk);
		game_state <= m.gs;
		blue_x     <= m.blue_x;
		blue_y     <= m.blue_y;
		blue_dir   <= m.blue_dir;
		red_x      <= m.red_x;
		red_y      <= m.red_y;
		red_dir    <= m.red_dir;
		exp_steps.delete();
		fb_mem.delete();
		write_count = 0;
		predict_player(P_BLUE, m.gs, m.blue_x, m.blue_y, m.blue_dir);
		predict_player(P_RED, m.gs, m.red_x, m.red_y, m.red_dir);
		// map sweep covers the whole grid once
		if (m.gs == GS_READY)
			repeat (GRID_CELLS + 10) @(posedge Clk);
		else
			wait_quiet();
		check_value({m.name, " write count"}, 4 * exp_steps.size(), write_count);
		foreach (exp_steps[j])
		begin
			for (int r = 0; r < TILE_ROWS; r++)
			begin
				addr   = fb_address(exp_steps[j].x, exp_steps[j].y, r);
				actual = fb_mem.exists(addr) ? fb_mem[addr] : 16'hxxxx;
				check_value($sformatf("%s word %0h", m.name, addr),
					expected_word(exp_steps[j].player, exp_steps[j].kind, r), actual);
			end
		end
		check_value({m.name, " collision_blue"}, m.exp_col_blue, collision_blue);
		check_value({m.name, " collision_red"}, m.exp_col_red, collision_red);
	endtask

	// run limit scales with the number of moves
	initial
	begin
		int limit;
		wait (table_ready);
		limit = moves.size() * 400 + GRID_CELLS + 200;
		repeat (limit) @(posedge Clk);
		$display("timeout: the moves did not complete within %0d cycles", limit);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	initial
	begin
		void'($urandom(32'h7126_8891));
		Clk         = 1'b0;
		rst_n       = 1'b0;
		game_state  = GS_TITLE;
		blue_x      = '0;
		blue_y      = '0;
		red_x       = '0;
		red_y       = '0;
		blue_dir    = DIR_UP;
		red_dir     = DIR_UP;
		fb_ack      = 1'b0;
		write_count = 0;
		for (int p = 0; p < 2; p++)
		begin
			last_x[p]   = '0;
			last_y[p]   = '0;
			last_dir[p] = DIR_UP;
		end
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge Clk);
		rst_n <= 1'b1;
		foreach (moves[i])
			apply_move(moves[i]);
		@(posedge Clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
source/trail_pkg.sv
source/trail_step_if.sv
source/trail_classifier.sv
source/trail_tile_rom.sv
source/trail_map.sv
source/trail_writer.sv
source/trail_engine.sv
test/tb_trail_engine.sv
